/* nnLayer.f */
+incdir+tests
src/nnFixedPkg.sv
src/nnLayerPkg.sv
src/featureBus.sv
src/featureLoader.sv
src/neuron.sv
src/resultCollector.sv
src/nnLayerTop.sv
tests/tbNnLayer.sv

/* Makefile */
SIM = verilator
SIMFLAGS = --binary --timing -Wno-fatal
TOP = tbNnLayer
FILELIST = nnLayer.f
OBJDIR = obj_dir

BIN = $(OBJDIR)/V$(TOP)
SOURCES = $(wildcard src/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

/* tests/tbNnLayerModel.svh */
`ifndef TB_NN_LAYER_MODEL_SVH
`define TB_NN_LAYER_MODEL_SVH

// Expected output of neuron n for one full input vector.
function automatic activation_t refNeuron(input int n, input vector_t vec);
	acc_t acc;
	acc_t prod;
	acc = acc_t'(Biases[n]);
	for (int i = 0; i < NumInputs; i++)
	begin
		prod = acc_t'(vec[i]) * acc_t'(Weights[n][i]);
		acc = acc + (prod >>> FracBits);
	end
	if (acc < 0)
		return '0;
	else if (acc > ActMax)
		return activation_t'(ActMax);
	else
		return activation_t'(acc[15:0]);
endfunction

// 32-bit xorshift with shifts 13, 17 and 5.
function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

`endif

/* tests/tbNnLayer.sv */
`timescale 1ns/100ps

module tbNnLayer;
	import nnFixedPkg::*;
	import nnLayerPkg::*;

	typedef activation_t vector_t [NumInputs];

	localparam int NumRandom = 8;
	localparam int NumPressure = 4;
	localparam int NumJitter = 4;
	localparam int NumVectors = 3 + NumRandom + NumPressure + NumJitter;
	localparam int CyclesPerVector = 200;
	localparam int DrainLimit = 2 * CyclesPerVector;

	logic clk;
	logic reset;
	logic inReq;
	activation_t inData;
	logic inAck;
	logic outReq;
	activation_t outData;
	neuronIndex_t outIndex;
	logic outAck;

	activation_t expValues [$];
	neuronIndex_t expIndices [$];
	int outCount = 0;
	int ackMaxDelay = 3;
	logic [31:0] stimState = 32'd19432;
	logic [31:0] ackState = ~32'd19432;

	`include "tbNnLayerModel.svh"

	nnLayerTop dut0 (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.outReq(outReq),
		.outData(outData),
		.outIndex(outIndex),
		.outAck(outAck)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	function automatic int stimRandom(input int limit);
		stimState = xorshift(stimState);
		return int'(stimState % (limit + 1));
	endfunction

	function automatic int ackRandom(input int limit);
		ackState = xorshift(ackState);
		return int'(ackState % (limit + 1));
	endfunction

	function automatic activation_t randomActivation();
		stimState = xorshift(stimState);
		return activation_t'(stimState[31:16]);
	endfunction

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "Stopping after the first error.");
	endtask

	task automatic checkValue(input activation_t actual, input activation_t expected);
		if (actual !== expected)
			reportFailure($sformatf("Fail at %0d ns: outData expected %0d, got %0d",
				$time, expected, actual));
	endtask

	task automatic checkIndex(input neuronIndex_t actual, input neuronIndex_t expected);
		if (actual !== expected)
			reportFailure($sformatf("Fail at %0d ns: outIndex expected %0d, got %0d",
				$time, expected, actual));
	endtask

	task automatic checkBit(input logic actual, input logic expected, input string what);
		if (actual !== expected)
			reportFailure($sformatf("Fail at %0d ns: %s expected %b, got %b",
				$time, what, expected, actual));
	endtask

	task automatic idleCycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// Queues the expected results, then runs the input handshake for each element.
	task automatic sendVector(input vector_t vec, input int maxGap);
		for (int n = 0; n < NumNeurons; n++)
		begin
			expValues.push_back(refNeuron(n, vec));
			expIndices.push_back(neuronIndex_t'(n));
		end
		for (int i = 0; i < NumInputs; i++)
		begin
			idleCycles(stimRandom(maxGap));
			inData <= vec[i];
			inReq <= 1'b1;
			@(posedge clk);
			while (!inAck)
				@(posedge clk);
			idleCycles(stimRandom(maxGap));
			inReq <= 1'b0;
			@(posedge clk);
			while (inAck)
				@(posedge clk);
		end
	endtask

	// Output sink and comparison.
	initial
	begin
		forever
		begin
			@(posedge clk);
			if (outReq === 1'b1)
			begin
				if (expValues.size() == 0)
					reportFailure("An output appeared while no result was expected.");
				else
				begin
					checkIndex(outIndex, expIndices.pop_front());
					checkValue(outData, expValues.pop_front());
					idleCycles(ackRandom(ackMaxDelay));
					outAck <= 1'b1;
					@(posedge clk);
					while (outReq)
						@(posedge clk);
					outAck <= 1'b0;
					outCount++;
				end
			end
		end
	end

	initial
	begin
		repeat (CyclesPerVector * NumVectors) @(posedge clk);
		reportFailure("Timeout: the layer stopped making progress on its handshakes.");
	end

	initial
	begin
		vector_t vec;
		int drainCycles;
		reset = 1'b1;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		idleCycles(3);
		checkBit(outReq, 1'b0, "outReq after reset");
		checkBit(inAck, 1'b0, "inAck after reset");

		// A zero vector leaves only the rectified bias.
		vec = '{default: '0};
		sendVector(vec, 0);
		vec = '{default: activation_t'(16'h7fff)};
		sendVector(vec, 0);
		vec = '{default: activation_t'(16'h8000)};
		sendVector(vec, 0);
		for (int v = 0; v < NumRandom; v++)
		begin
			foreach (vec[i])
				vec[i] = randomActivation();
			sendVector(vec, 0);
		end

		// Slow sink, so the loader has to stall on the last input.
		ackMaxDelay = 30;
		for (int v = 0; v < NumPressure; v++)
		begin
			foreach (vec[i])
				vec[i] = randomActivation();
			sendVector(vec, 0);
		end

		ackMaxDelay = 3;
		for (int v = 0; v < NumJitter; v++)
		begin
			foreach (vec[i])
				vec[i] = randomActivation();
			sendVector(vec, 4);
		end

		drainCycles = 0;
		while (outCount < NumVectors * NumNeurons && drainCycles < DrainLimit)
		begin
			@(posedge clk);
			drainCycles++;
		end
		idleCycles(40);
		if (outCount != NumVectors * NumNeurons)
			reportFailure("The layer produced fewer outputs than expected.");
		else
		begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

/* src/nnLayerTop.sv */
`timescale 1ns/100ps

module nnLayerTop (
	input logic clk,
	input logic reset,
	input logic inReq,
	input nnFixedPkg::activation_t inData,
	output logic inAck,
	output logic outReq,
	output nnFixedPkg::activation_t outData,
	output nnLayerPkg::neuronIndex_t outIndex,
	input logic outAck
);
	import nnFixedPkg::*;
	import nnLayerPkg::*;

	featureBus bus ();

	activation_t results [NumNeurons];
	logic bufferFree;

	featureLoader loader (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.bufferFree(bufferFree),
		.bus(bus)
	);

	for (genvar i = 0; i < NumNeurons; i++)
	begin : neurons
		neuron #(
			.NeuronId(i)
		) neuronInst (
			.clk(clk),
			.reset(reset),
			.bus(bus),
			.result(results[i])
		);
	end

	resultCollector collector (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.results(results),
		.bufferFree(bufferFree),
		.outReq(outReq),
		.outData(outData),
		.outIndex(outIndex),
		.outAck(outAck)
	);

endmodule

/* src/resultCollector.sv */
`timescale 1ns/100ps

module resultCollector (
	input logic clk,
	input logic reset,
	featureBus.listener bus,
	input nnFixedPkg::activation_t results [nnLayerPkg::NumNeurons],
	output logic bufferFree,
	output logic outReq,
	output nnFixedPkg::activation_t outData,
	output nnLayerPkg::neuronIndex_t outIndex,
	input logic outAck
);
	import nnFixedPkg::*;
	import nnLayerPkg::*;

	localparam neuronIndex_t LastNeuron = neuronIndex_t'(NumNeurons - 1);

	typedef enum logic [1:0] {
		idle,
		present,
		waitRelease
	} state_t;

	state_t state;
	activation_t buffer [NumNeurons];
	logic latchPending;
	neuronIndex_t pointer;

	assign bufferFree = (state == idle);
	assign outReq = (state == present);
	assign outData = buffer[pointer];
	assign outIndex = pointer;

	// Neuron results become valid the cycle after the last feed.
	always_ff @(posedge clk)
	begin
		if (reset)
			latchPending <= 1'b0;
		else
			latchPending <= bus.feed && bus.last;
	end

	always_ff @(posedge clk)
	begin
		if (state == idle && latchPending)
			buffer <= results;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			pointer <= '0;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (latchPending)
					begin
						pointer <= '0;
						state <= present;
					end
				end
				present:
				begin
					if (outAck)
						state <= waitRelease;
				end
				waitRelease:
				begin
					// Wait for the sink to drop its ack before the next word.
					if (!outAck)
					begin
						if (pointer == LastNeuron)
							state <= idle;
						else
						begin
							pointer <= pointer + 1'b1;
							state <= present;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

/* src/neuron.sv */
`timescale 1ns/100ps

module neuron #(
	parameter int NeuronId = 0
) (
	input logic clk,
	input logic reset,
	featureBus.listener bus,
	output nnFixedPkg::activation_t result
);
	import nnFixedPkg::*;
	import nnLayerPkg::*;

	inputIndex_t index;
	weight_t weight;
	acc_t fullProduct;
	acc_t product;
	acc_t base;
	acc_t sum;
	activation_t clipped;
	acc_t acc;

	assign weight = Weights[NeuronId][index];

	// A single multiplier, shared by all inputs of the vector.
	assign fullProduct = bus.activation * weight;
	assign product = fullProduct >>> FracBits;

	// The first input restarts the sum at the bias.
	assign base = bus.first ? acc_t'(Biases[NeuronId]) : acc;
	assign sum = base + product;

	always_comb
	begin
		if (sum < 0)
			clipped = '0;
		else if (sum > ActMax)
			clipped = activation_t'(ActMax);
		else
			clipped = sum[15:0];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			index <= '0;
			acc <= '0;
			result <= '0;
		end
		else if (bus.feed)
		begin
			acc <= sum;
			index <= bus.last ? '0 : index + 1'b1;
			if (bus.last)
				result <= clipped;
		end
	end

endmodule

/* src/featureLoader.sv */
`timescale 1ns/100ps

module featureLoader (
	input logic clk,
	input logic reset,
	input logic inReq,
	input nnFixedPkg::activation_t inData,
	output logic inAck,
	input logic bufferFree,
	featureBus.loader bus
);
	import nnLayerPkg::*;

	localparam inputIndex_t LastInput = inputIndex_t'(NumInputs - 1);

	typedef enum logic {
		waitReq,
		waitRelease
	} state_t;

	state_t state;
	inputIndex_t count;
	logic canFeed;

	// The final input of a vector is held back until the collector has room.
	assign canFeed = inReq && ((count != LastInput) || bufferFree);
	assign inAck = (state == waitRelease);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= waitReq;
			count <= '0;
			bus.feed <= 1'b0;
			bus.first <= 1'b0;
			bus.last <= 1'b0;
		end
		else
		begin
			bus.feed <= 1'b0;
			case (state)
				waitReq:
				begin
					if (canFeed)
					begin
						bus.feed <= 1'b1;
						bus.first <= (count == '0);
						bus.last <= (count == LastInput);
						count <= (count == LastInput) ? '0 : count + 1'b1;
						state <= waitRelease;
					end
				end
				waitRelease:
				begin
					if (!inReq)
						state <= waitReq;
				end
				default: state <= waitReq;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == waitReq && canFeed)
			bus.activation <= inData;
	end

endmodule

/* src/featureBus.sv */
`timescale 1ns/100ps

interface featureBus;
	import nnFixedPkg::*;

	// One-cycle strobe that carries activation to every listener.
	logic feed;
	logic first;
	logic last;
	activation_t activation;

	modport loader (
		output feed,
		output first,
		output last,
		output activation
	);

	modport listener (
		input feed,
		input first,
		input last,
		input activation
	);

endinterface

/* src/nnLayerPkg.sv */
package nnLayerPkg;

	localparam int NumInputs = 15;
	localparam int NumNeurons = 8;

	typedef logic [3:0] inputIndex_t;
	typedef logic [2:0] neuronIndex_t;

	// One row per neuron, one column per input, Q8.8.
	localparam nnFixedPkg::weight_t Weights [NumNeurons][NumInputs] = '{
		'{16'sd96, -16'sd45, 16'sd210, -16'sd12, 16'sd64, -16'sd180, 16'sd33, 16'sd150,
			-16'sd77, 16'sd20, -16'sd256, 16'sd128, 16'sd5, -16'sd90, 16'sd240},
		'{-16'sd130, 16'sd88, -16'sd14, 16'sd200, -16'sd66, 16'sd42, -16'sd250, 16'sd9,
			16'sd175, -16'sd31, 16'sd60, -16'sd118, 16'sd222, -16'sd3, 16'sd71},
		'{16'sd300, 16'sd17, -16'sd205, 16'sd58, 16'sd141, -16'sd26, 16'sd99, -16'sd164,
			16'sd2, 16'sd230, -16'sd47, 16'sd81, -16'sd199, 16'sd123, -16'sd8},
		'{-16'sd22, -16'sd140, 16'sd76, -16'sd288, 16'sd13, 16'sd190, -16'sd55, 16'sd36,
			-16'sd212, 16'sd104, 16'sd167, -16'sd73, 16'sd40, 16'sd259, -16'sd117},
		'{16'sd51, 16'sd233, -16'sd98, 16'sd7, -16'sd171, 16'sd84, 16'sd146, -16'sd239,
			16'sd62, -16'sd18, 16'sd112, 16'sd29, -16'sd154, 16'sd67, 16'sd195},
		'{-16'sd270, 16'sd39, 16'sd158, -16'sd101, 16'sd224, -16'sd63, 16'sd11, 16'sd187,
			-16'sd136, 16'sd95, -16'sd41, 16'sd248, -16'sd27, -16'sd83, 16'sd16},
		'{16'sd144, -16'sd208, 16'sd25, 16'sd172, -16'sd4, -16'sd126, 16'sd263, -16'sd59,
			16'sd110, -16'sd193, 16'sd48, 16'sd0, 16'sd137, -16'sd245, 16'sd86},
		'{-16'sd69, 16'sd121, 16'sd277, -16'sd160, 16'sd93, 16'sd15, -16'sd108, 16'sd201,
			16'sd34, 16'sd160, -16'sd226, 16'sd57, 16'sd183, 16'sd44, -16'sd134}
	};

	// Per-neuron bias, Q8.8.
	localparam nnFixedPkg::weight_t Biases [NumNeurons] = '{
		16'sd128, -16'sd64, 16'sd512, -16'sd300, 16'sd0, 16'sd256, -16'sd32, 16'sd700
	};

endpackage

/* src/nnFixedPkg.sv */
package nnFixedPkg;

	// Activations, weights and biases share the Q8.8 format.
	localparam int FracBits = 8;
	localparam int ActWidth = 16;
	localparam int AccWidth = 32;

	typedef logic signed [ActWidth-1:0] activation_t;
	typedef logic signed [ActWidth-1:0] weight_t;
	typedef logic signed [AccWidth-1:0] acc_t;

	// Largest positive activation; the rectifier clamps to this.
	localparam acc_t ActMax = acc_t'(32767);

endpackage
